// ==== txSequencer_settings.svh ====
`ifndef TX_SEQUENCER_SETTINGS_SVH
`define TX_SEQUENCER_SETTINGS_SVH

// transducer channels driven by the bank
`define TX_CHANNELS 8

// program memory address width
`define TX_ADDR_W 14

// wait field and phase delay widths
`define TX_DELAY_W 16
`define TX_PHASE_W 8

// instruction queue entries, also the initial fetch credits
`define TX_QUEUE_DEPTH 2

// cycles a fired channel stays high
`define TX_PULSE_CYCLES 4

`endif

// ==== txInstrPkg.sv ====
`include "txSequencer_settings.svh"

package txInstrPkg;

	typedef logic [`TX_ADDR_W-1:0] instrAddrT;

	// opcode [31:28], operand [27:20], spare [19:16], wait [15:0]
	typedef logic [31:0] instrWordT;

	typedef enum logic [3:0] {
		setTrig     = 4'd0,
		setLeds     = 4'd1,
		triggerRecv = 4'd2,
		firePulse   = 4'd5,
		programEnd  = 4'd15
	} opcodeT;

	typedef logic [7:0] operandT;
	typedef logic [`TX_DELAY_W-1:0] waitT;
	typedef logic [`TX_PHASE_W-1:0] phaseT;

	function automatic opcodeT opcodeOf(instrWordT word);
		return opcodeT'(word[31:28]);
	endfunction

	function automatic operandT operandOf(instrWordT word);
		return word[27:20];
	endfunction

	function automatic waitT waitOf(instrWordT word);
		return word[15:0];
	endfunction

endpackage

// ==== txControlPkg.sv ====
package txControlPkg;

	// operator commands, sampled every cycle
	typedef enum logic [7:0] {
		hardReset        = 8'd0,
		softReset        = 8'd1,
		loadProgram      = 8'd2,
		setTrigOutput    = 8'd4,
		setTrigRestLevel = 8'd5,
		testTrigOutput   = 8'd6,
		setLedOutput     = 8'd8,
		runProgram       = 8'd128
	} controlCmdT;

	typedef enum logic [2:0] {
		idle,
		manual,
		loading,
		running,
		done
	} modeT;

endpackage

// ==== instrQueueIf.sv ====
`timescale 1ns/1ps

interface instrQueueIf;

	import txInstrPkg::*;

	logic pushValid;
	instrWordT pushWord;
	logic creditReturn;
	// empties the queue and restores credits
	logic flush;

	modport producer (
		output pushValid,
		output pushWord,
		input creditReturn,
		input flush
	);

	modport consumer (
		input pushValid,
		input pushWord,
		output creditReturn,
		input flush
	);

endinterface

// ==== instructionFetch.sv ====
`timescale 1ns/1ps
`include "txSequencer_settings.svh"

module instructionFetch (
	input logic txCLK,
	input logic rstN,
	input txInstrPkg::instrAddrT programStartAddr,
	input txInstrPkg::instrWordT instrData,
	input logic runEnable,
	instrQueueIf.producer queue,
	output txInstrPkg::instrAddrT instrReadAddr
);

	localparam int CreditW = $clog2(`TX_QUEUE_DEPTH + 1);

	logic [CreditW-1:0] credits;
	logic readPending;
	logic issueRead;

	// each read reserves one queue slot ahead of time
	assign issueRead = runEnable && !queue.flush && (credits != '0);

	always_ff @(posedge txCLK)
	begin
		if (!rstN)
		begin
			instrReadAddr <= '0;
			credits <= CreditW'(`TX_QUEUE_DEPTH);
			readPending <= 1'b0;
			queue.pushValid <= 1'b0;
		end
		else if (queue.flush)
		begin
			instrReadAddr <= programStartAddr;
			credits <= CreditW'(`TX_QUEUE_DEPTH);
			readPending <= 1'b0;
			queue.pushValid <= 1'b0;
		end
		else
		begin
			if (issueRead)
				instrReadAddr <= instrReadAddr + 1'b1;
			credits <= credits - CreditW'(issueRead) + CreditW'(queue.creditReturn);
			readPending <= issueRead;
			queue.pushValid <= readPending;
		end
	end

	// memory answers one cycle after the read, word goes out the cycle after
	always_ff @(posedge txCLK)
	begin
		if (readPending)
			queue.pushWord <= instrData;
	end

	creditsBounded: assert property (@(posedge txCLK) disable iff (!rstN)
		credits <= CreditW'(`TX_QUEUE_DEPTH));

endmodule

// ==== instructionExecutor.sv ====
`timescale 1ns/1ps
`include "txSequencer_settings.svh"

module instructionExecutor (
	input logic txCLK,
	input logic rstN,
	input logic runEnable,
	input logic adcTriggerAck,
	input logic bankBusy,
	instrQueueIf.consumer queue,
	output txInstrPkg::operandT programTrig,
	output txInstrPkg::operandT programLed,
	output logic adcTrigger,
	output logic fireStart,
	output logic [`TX_CHANNELS-1:0] fireMask,
	output logic programDone
);

	import txInstrPkg::*;

	localparam int PtrW = ($clog2(`TX_QUEUE_DEPTH) > 0) ? $clog2(`TX_QUEUE_DEPTH) : 1;
	localparam int CountW = $clog2(`TX_QUEUE_DEPTH + 1);
	localparam logic [PtrW-1:0] LastPtr = PtrW'(`TX_QUEUE_DEPTH - 1);

	instrWordT queueMem [`TX_QUEUE_DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CountW-1:0] count;
	waitT waitCnt;
	instrWordT headWord;
	opcodeT headOp;
	operandT headOperand;
	logic pop;
	logic fireOk;

	assign headWord = queueMem[rdPtr];
	assign headOp = opcodeOf(headWord);
	assign headOperand = operandOf(headWord);

	// next instruction starts once the current wait has run out
	assign pop = runEnable && !queue.flush && !programDone && (count != '0) && (waitCnt == '0);

	// a second fire before the bank reports busy is dropped
	assign fireOk = pop && (headOp == firePulse) && !bankBusy && !fireStart;

	always_ff @(posedge txCLK)
	begin
		if (!rstN || queue.flush)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			waitCnt <= '0;
			programTrig <= '0;
			programLed <= '0;
			adcTrigger <= 1'b0;
			fireStart <= 1'b0;
			programDone <= 1'b0;
			queue.creditReturn <= 1'b0;
		end
		else
		begin
			queue.creditReturn <= pop;
			fireStart <= fireOk;
			if (queue.pushValid)
				wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
			count <= count + CountW'(queue.pushValid) - CountW'(pop);
			if (adcTrigger && adcTriggerAck)
				adcTrigger <= 1'b0;
			if (pop)
			begin
				waitCnt <= waitOf(headWord);
				case (headOp)
					setTrig: programTrig <= headOperand;
					setLeds: programLed <= headOperand;
					triggerRecv: adcTrigger <= 1'b1;
					programEnd: programDone <= 1'b1;
					default: ;
				endcase
			end
			else if (waitCnt != '0)
				waitCnt <= waitCnt - 1'b1;
		end
	end

	always_ff @(posedge txCLK)
	begin
		if (queue.pushValid)
			queueMem[wrPtr] <= queue.pushWord;
		if (fireOk)
			fireMask <= headOperand[`TX_CHANNELS-1:0];
	end

	// credits in fetch must keep pushes within the free entries
	noPushWhenFull: assert property (@(posedge txCLK) disable iff (!rstN)
		queue.pushValid |-> (count < CountW'(`TX_QUEUE_DEPTH)));

endmodule

// ==== pulseChannelBank.sv ====
`timescale 1ns/1ps
`include "txSequencer_settings.svh"

module pulseChannelBank (
	input logic txCLK,
	input logic rstN,
	input logic fireStart,
	input logic [`TX_CHANNELS-1:0] fireMask,
	input logic [`TX_CHANNELS-1:0] channelMask,
	input txInstrPkg::phaseT [`TX_CHANNELS-1:0] phaseDelays,
	input logic flush,
	output logic [`TX_CHANNELS-1:0] transducerOut,
	output logic bankBusy
);

	import txInstrPkg::*;

	localparam int PulseW = $clog2(`TX_PULSE_CYCLES + 1);

	logic [`TX_CHANNELS-1:0] pending;
	logic accept;

	assign bankBusy = (|pending) || (|transducerOut);
	assign accept = fireStart && !bankBusy;

	for (genvar ch = 0; ch < `TX_CHANNELS; ch++)
	begin : gChannel
		phaseT delayCnt;
		logic [PulseW-1:0] pulseCnt;
		logic waiting;
		logic armed;

		assign armed = fireMask[ch] & channelMask[ch];
		assign pending[ch] = waiting;
		assign transducerOut[ch] = (pulseCnt != '0);

		always_ff @(posedge txCLK)
		begin
			if (!rstN || flush)
			begin
				waiting <= 1'b0;
				pulseCnt <= '0;
			end
			else if (accept && armed)
			begin
				// zero phase goes high right after the fire start
				if (phaseDelays[ch] == '0)
					pulseCnt <= PulseW'(`TX_PULSE_CYCLES);
				else
					waiting <= 1'b1;
			end
			else if (waiting && (delayCnt == phaseT'(1)))
			begin
				waiting <= 1'b0;
				pulseCnt <= PulseW'(`TX_PULSE_CYCLES);
			end
			else if (pulseCnt != '0)
				pulseCnt <= pulseCnt - 1'b1;
		end

		always_ff @(posedge txCLK)
		begin
			if (accept)
				delayCnt <= phaseDelays[ch];
			else if (waiting)
				delayCnt <= delayCnt - 1'b1;
		end
	end

	// executor holds back fires until the bank is idle again
	fireOnlyWhenIdle: assert property (@(posedge txCLK) disable iff (!rstN)
		fireStart |-> !bankBusy);

endmodule

// ==== controlModeDecoder.sv ====
`timescale 1ns/1ps

module controlModeDecoder (
	input logic txCLK,
	input logic rstN,
	input txControlPkg::controlCmdT controlCmd,
	input logic [7:0] ledReg,
	input logic [7:0] trigReg,
	input logic [7:0] trigRestLevelReg,
	input txInstrPkg::operandT programTrig,
	input txInstrPkg::operandT programLed,
	input logic programDone,
	output logic [7:0] trigOut,
	output logic [7:0] ledOut,
	output logic runEnable,
	output logic flush
);

	import txControlPkg::*;

	controlCmdT cmdQ;
	modeT mode;
	logic [7:0] restLevel;
	logic [7:0] manualTrig;
	logic [7:0] manualLed;

	always_ff @(posedge txCLK)
	begin
		if (!rstN)
		begin
			cmdQ <= hardReset;
			mode <= idle;
			restLevel <= '0;
			manualTrig <= '0;
			manualLed <= '0;
		end
		else
		begin
			cmdQ <= controlCmd;
			case (controlCmd)
				hardReset:
				begin
					mode <= idle;
					restLevel <= '0;
					manualTrig <= '0;
					manualLed <= '0;
				end
				softReset: mode <= idle;
				loadProgram: mode <= loading;
				setTrigOutput:
				begin
					mode <= manual;
					manualTrig <= trigReg;
				end
				setTrigRestLevel:
				begin
					mode <= manual;
					restLevel <= trigRestLevelReg;
					manualTrig <= trigRestLevelReg;
				end
				testTrigOutput:
				begin
					mode <= manual;
					manualTrig <= trigReg ^ restLevel;
				end
				setLedOutput:
				begin
					mode <= manual;
					manualLed <= ledReg;
				end
				runProgram: mode <= programDone ? done : running;
				default: mode <= idle;
			endcase
		end
	end

	// outputs sit at rest unless a program or a manual command owns them
	always_comb
	begin
		case (mode)
			manual:
			begin
				trigOut = manualTrig;
				ledOut = manualLed;
			end
			running, done:
			begin
				trigOut = programTrig ^ restLevel;
				ledOut = programLed;
			end
			default:
			begin
				trigOut = restLevel;
				ledOut = '0;
			end
		endcase
	end

	assign runEnable = (mode == running);
	assign flush = (cmdQ == hardReset) || (cmdQ == softReset) || (cmdQ == loadProgram);

endmodule

// ==== txSequencer.sv ====
`timescale 1ns/1ps
`include "txSequencer_settings.svh"

module txSequencer (
	input logic txCLK,
	input logic rstN,
	input txControlPkg::controlCmdT controlCmd,
	input txInstrPkg::instrAddrT programStartAddr,
	input txInstrPkg::instrWordT instrData,
	input logic [`TX_CHANNELS-1:0] channelMask,
	input txInstrPkg::phaseT [`TX_CHANNELS-1:0] phaseDelays,
	input logic [7:0] ledReg,
	input logic [7:0] trigReg,
	input logic [7:0] trigRestLevelReg,
	input logic adcTriggerAck,
	output txInstrPkg::instrAddrT instrReadAddr,
	output logic [`TX_CHANNELS-1:0] transducerOut,
	output logic [7:0] trigOut,
	output logic [7:0] ledOut,
	output logic adcTrigger,
	output logic programDone
);

	import txInstrPkg::*;

	operandT programTrig;
	operandT programLed;
	logic runEnable;
	logic fireStart;
	logic [`TX_CHANNELS-1:0] fireMask;
	logic bankBusy;

	instrQueueIf queueBus ();

	controlModeDecoder modeDecoder0 (
		.txCLK(txCLK),
		.rstN(rstN),
		.controlCmd(controlCmd),
		.ledReg(ledReg),
		.trigReg(trigReg),
		.trigRestLevelReg(trigRestLevelReg),
		.programTrig(programTrig),
		.programLed(programLed),
		.programDone(programDone),
		.trigOut(trigOut),
		.ledOut(ledOut),
		.runEnable(runEnable),
		.flush(queueBus.flush)
	);

	instructionFetch fetch0 (
		.txCLK(txCLK),
		.rstN(rstN),
		.programStartAddr(programStartAddr),
		.instrData(instrData),
		.runEnable(runEnable),
		.queue(queueBus.producer),
		.instrReadAddr(instrReadAddr)
	);

	instructionExecutor executor0 (
		.txCLK(txCLK),
		.rstN(rstN),
		.runEnable(runEnable),
		.adcTriggerAck(adcTriggerAck),
		.bankBusy(bankBusy),
		.queue(queueBus.consumer),
		.programTrig(programTrig),
		.programLed(programLed),
		.adcTrigger(adcTrigger),
		.fireStart(fireStart),
		.fireMask(fireMask),
		.programDone(programDone)
	);

	pulseChannelBank channelBank0 (
		.txCLK(txCLK),
		.rstN(rstN),
		.fireStart(fireStart),
		.fireMask(fireMask),
		.channelMask(channelMask),
		.phaseDelays(phaseDelays),
		.flush(queueBus.flush),
		.transducerOut(transducerOut),
		.bankBusy(bankBusy)
	);

endmodule

// ==== txSequencer_tb.sv ====
`timescale 1ns/1ps
`include "txSequencer_settings.svh"

module txSequencer_tb;

	import txControlPkg::*;
	import txInstrPkg::*;

	localparam int MaxCases = 8;
	localparam int MaxWords = 16;

	logic txCLK = 1'b0;
	logic rstN;
	controlCmdT controlCmd;
	instrAddrT programStartAddr;
	instrWordT instrData = '0;
	logic [`TX_CHANNELS-1:0] channelMask;
	phaseT [`TX_CHANNELS-1:0] phaseDelays;
	logic [7:0] ledReg;
	logic [7:0] trigReg;
	logic [7:0] trigRestLevelReg;
	logic adcTriggerAck = 1'b0;
	instrAddrT instrReadAddr;
	logic [`TX_CHANNELS-1:0] transducerOut;
	logic [7:0] trigOut;
	logic [7:0] ledOut;
	logic adcTrigger;
	logic programDone;

	instrWordT mem [1 << `TX_ADDR_W];
	// columns: start, length, abort, rest, led, trig, mask, then expected trig, led, fired
	logic [31:0] caseReg [MaxCases][10];
	phaseT casePhase [MaxCases][`TX_CHANNELS];
	instrWordT caseWord [MaxCases][MaxWords];
	int numCases;
	int watchdogCycles;
	logic limitReady = 1'b0;

	logic seqWatch = 1'b0;
	logic pulseWatch = 1'b0;
	logic [7:0] lastTrig;
	logic [7:0] lastLed;
	logic [7:0] gotTrig [$];
	logic [7:0] gotLed [$];
	logic [7:0] wantTrig [$];
	logic [7:0] wantLed [$];
	int cycleNo = 0;
	int riseAt [`TX_CHANNELS];
	int highLen [`TX_CHANNELS];
	logic [`TX_CHANNELS-1:0] prevOut;
	logic [`TX_CHANNELS-1:0] firedMask;
	int adcSeen;

	txSequencer dut0 (.*);

	always #10 txCLK = ~txCLK;

	// program memory with one cycle read latency
	always @(posedge txCLK)
		instrData <= mem[instrReadAddr];

	task automatic failRun(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			failRun($sformatf("Error at %0d ns: %s expected %0h, got %0h", $time, name,
				expected, actual));
	endtask

	// returns once the command has reached the outputs
	task automatic applyCommand(input controlCmdT cmd);
		@(posedge txCLK);
		controlCmd <= cmd;
		@(posedge txCLK);
		@(negedge txCLK);
	endtask

	task automatic startRun(input int k);
		applyCommand(loadProgram);
		@(posedge txCLK);
		controlCmd <= runProgram;
		gotTrig.delete();
		gotLed.delete();
		lastTrig = caseReg[k][3][7:0];
		lastLed = '0;
		prevOut = '0;
		firedMask = '0;
		adcSeen = 0;
		for (int ch = 0; ch < `TX_CHANNELS; ch++)
			highLen[ch] = 0;
		seqWatch = 1'b1;
		pulseWatch = 1'b1;
	endtask

	task automatic runCase(input int k);
		logic [7:0] rest;
		logic [7:0] trig;
		logic [7:0] prevTrig;
		logic [7:0] prevLed;
		logic [7:0] fireOp;
		instrWordT w;
		int adcWant;
		int first;
		rest = caseReg[k][3][7:0];
		trig = caseReg[k][5][7:0];
		@(posedge txCLK);
		programStartAddr <= caseReg[k][0][`TX_ADDR_W-1:0];
		trigRestLevelReg <= rest;
		ledReg <= caseReg[k][4][7:0];
		trigReg <= trig;
		channelMask <= caseReg[k][6][`TX_CHANNELS-1:0];
		for (int ch = 0; ch < `TX_CHANNELS; ch++)
			phaseDelays[ch] <= casePhase[k][ch];
		for (int i = 0; i < caseReg[k][1]; i++)
			mem[caseReg[k][0][`TX_ADDR_W-1:0] + i] = caseWord[k][i];

		applyCommand(setTrigRestLevel);
		applyCommand(softReset);
		checkValue("trigOut", rest, trigOut);
		applyCommand(setLedOutput);
		checkValue("ledOut", caseReg[k][4][7:0], ledOut);
		applyCommand(testTrigOutput);
		checkValue("trigOut", trig ^ rest, trigOut);
		applyCommand(setTrigOutput);
		checkValue("trigOut", trig, trigOut);

		// expected output changes in program order
		wantTrig.delete();
		wantLed.delete();
		prevTrig = rest;
		prevLed = '0;
		fireOp = '0;
		adcWant = 0;
		for (int i = 0; i < caseReg[k][1]; i++)
		begin
			w = caseWord[k][i];
			case (opcodeT'(w[31:28]))
				setTrig:
				begin
					if ((w[27:20] ^ rest) != prevTrig)
						wantTrig.push_back(w[27:20] ^ rest);
					prevTrig = w[27:20] ^ rest;
				end
				setLeds:
				begin
					if (w[27:20] != prevLed)
						wantLed.push_back(w[27:20]);
					prevLed = w[27:20];
				end
				triggerRecv: adcWant++;
				firePulse: fireOp = w[27:20];
				default: ;
			endcase
		end

		startRun(k);
		if (caseReg[k][2] != 0)
		begin
			// soft reset while the pulse is still going
			@(negedge txCLK);
			while (transducerOut == '0)
				@(negedge txCLK);
			seqWatch = 1'b0;
			pulseWatch = 1'b0;
			applyCommand(softReset);
			@(posedge txCLK);
			@(negedge txCLK);
			checkValue("transducerOut", 0, transducerOut);
			checkValue("trigOut", rest, trigOut);
			startRun(k);
		end
		@(negedge txCLK);
		while (programDone !== 1'b1)
			@(negedge txCLK);
		seqWatch = 1'b0;
		while (transducerOut !== '0)
			@(negedge txCLK);
		@(posedge txCLK);
		pulseWatch = 1'b0;

		checkValue("trigOut", caseReg[k][7], trigOut);
		checkValue("ledOut", caseReg[k][8], ledOut);
		checkValue("trigOut change count", wantTrig.size(), gotTrig.size());
		for (int i = 0; i < wantTrig.size(); i++)
			checkValue($sformatf("trigOut change %0d", i), wantTrig[i], gotTrig[i]);
		checkValue("ledOut change count", wantLed.size(), gotLed.size());
		for (int i = 0; i < wantLed.size(); i++)
			checkValue($sformatf("ledOut change %0d", i), wantLed[i], gotLed[i]);
		checkValue("fired channels", fireOp & caseReg[k][6][7:0], firedMask);
		checkValue("fired channels from cases file", caseReg[k][9], firedMask);
		checkValue("adcTrigger handshakes", adcWant, adcSeen);
		first = -1;
		for (int ch = 0; ch < `TX_CHANNELS; ch++)
			if (firedMask[ch])
			begin
				if (first < 0)
					first = ch;
				else
					checkValue($sformatf("rise offset of transducerOut[%0d]", ch),
						int'(casePhase[k][ch]) - int'(casePhase[k][first]),
						riseAt[ch] - riseAt[first]);
			end
	endtask

	always @(negedge txCLK)
	begin
		cycleNo = cycleNo + 1;
		if (seqWatch)
		begin
			if (trigOut !== lastTrig)
				gotTrig.push_back(trigOut);
			if (ledOut !== lastLed)
				gotLed.push_back(ledOut);
			lastTrig = trigOut;
			lastLed = ledOut;
		end
		if (pulseWatch)
			for (int ch = 0; ch < `TX_CHANNELS; ch++)
			begin
				if (transducerOut[ch] && !prevOut[ch])
				begin
					if (firedMask[ch])
						failRun($sformatf("transducerOut[%0d] pulsed twice in one run", ch));
					riseAt[ch] = cycleNo;
					firedMask[ch] = 1'b1;
				end
				if (transducerOut[ch])
					highLen[ch]++;
				else if (prevOut[ch])
					checkValue($sformatf("transducerOut[%0d] high cycles", ch),
						`TX_PULSE_CYCLES, highLen[ch]);
				prevOut[ch] = transducerOut[ch];
			end
	end

	// ADC side answers each trigger after a random delay
	initial
	begin : adcResponder
		int ackDelay;
		void'($urandom(67));
		forever
		begin
			@(negedge txCLK);
			if (adcTrigger === 1'b1)
			begin
				ackDelay = 1 + ($urandom % 8);
				repeat (ackDelay)
				begin
					@(negedge txCLK);
					checkValue("adcTrigger", 1, adcTrigger);
				end
				@(posedge txCLK);
				adcTriggerAck <= 1'b1;
				@(posedge txCLK);
				adcTriggerAck <= 1'b0;
				@(negedge txCLK);
				checkValue("adcTrigger", 0, adcTrigger);
				adcSeen++;
			end
		end
	end

	initial
	begin
		wait (limitReady);
		repeat (watchdogCycles) @(posedge txCLK);
		failRun("watchdog expired before all test cases finished");
	end

	initial
	begin
		int fd;
		int rc;
		int maxWait;
		logic [8*200-1:0] line;
		rstN = 1'b0;
		controlCmd = hardReset;
		programStartAddr = '0;
		channelMask = '0;
		phaseDelays = '0;
		ledReg = '0;
		trigReg = '0;
		trigRestLevelReg = '0;
		// unused words read as program end with the address in the wait field
		for (int a = 0; a < (1 << `TX_ADDR_W); a++)
			mem[a] = 32'hF000_0000 | a;

		fd = $fopen("txSequencer_cases.txt", "r");
		if (fd == 0)
			failRun("cannot open txSequencer_cases.txt");
		rc = $fgets(line, fd);
		rc = $fgets(line, fd);
		numCases = 0;
		watchdogCycles = 200;
		while (numCases < MaxCases && $fscanf(fd, "%h %h %h %h %h %h %h",
			caseReg[numCases][0], caseReg[numCases][1], caseReg[numCases][2],
			caseReg[numCases][3], caseReg[numCases][4], caseReg[numCases][5],
			caseReg[numCases][6]) == 7)
		begin
			for (int ch = 0; ch < `TX_CHANNELS; ch++)
				rc = $fscanf(fd, "%h", casePhase[numCases][ch]);
			rc = $fscanf(fd, "%h %h %h", caseReg[numCases][7], caseReg[numCases][8],
				caseReg[numCases][9]);
			if (rc != 3 || caseReg[numCases][1] > MaxWords)
				failRun("malformed test case in txSequencer_cases.txt");
			maxWait = 0;
			for (int i = 0; i < caseReg[numCases][1]; i++)
			begin
				rc = $fscanf(fd, "%h", caseWord[numCases][i]);
				if (caseWord[numCases][i][15:0] > maxWait)
					maxWait = caseWord[numCases][i][15:0];
			end
			watchdogCycles += caseReg[numCases][1] * (maxWait + 40);
			numCases++;
		end
		$fclose(fd);
		limitReady = 1'b1;

		repeat (4) @(posedge txCLK);
		rstN <= 1'b1;
		@(negedge txCLK);
		checkValue("instrReadAddr", 0, instrReadAddr);
		checkValue("transducerOut", 0, transducerOut);
		checkValue("trigOut", 0, trigOut);
		checkValue("ledOut", 0, ledOut);
		checkValue("adcTrigger", 0, adcTrigger);
		checkValue("programDone", 0, programDone);

		for (int k = 0; k < numCases; k++)
			runCase(k);

		if (numCases > 0)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
			failRun("no test case was read from txSequencer_cases.txt");
	end

endmodule

// ==== txSequencer_cases.txt ====
# start len abort rest led trig chanMask phase0..phase7 expTrig expLed expFired (all hex)
# next line holds the program words: opcode[31:28] operand[27:20] wait[15:0]
0010 5 0 00 3C A5 FF 00 00 00 00 00 00 00 00 C3 FF 00
05A00003 18100002 0C300001 1FF00000 F0000000
0100 5 0 0F 11 22 7E 03 00 05 02 07 01 04 06 3F 44 74
03000002 20000014 5F500020 14400001 F0000000
0200 5 1 81 00 FF 0F 00 01 02 03 00 00 00 00 86 5A 0F
01800001 15A00000 50F00200 00700003 F0000000
3FF0 6 0 00 99 66 F0 08 08 08 08 0A 00 0A 03 00 99 A0
20000014 00000000 5AA00020 20000014 19900000 F0000000

// ==== txSequencer.f ====
+incdir+.
txInstrPkg.sv
txControlPkg.sv
instrQueueIf.sv
instructionFetch.sv
instructionExecutor.sv
pulseChannelBank.sv
controlModeDecoder.sv
txSequencer.sv
txSequencer_tb.sv
